/* hw/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// array geometry after the 8x8 cut
`define CONV_ROWS 8             // output channels
`define CONV_COLS 8             // input channels

// datapath widths
`define CONV_DATA_W 32          // glb bus in both directions
`define CONV_ACT_W 8            // signed weight or ifmap value
`define CONV_PSUM_W 16          // partial sum and wraps on overflow

// how values pack onto one bus beat
`define CONV_ACT_PER_BEAT 4
`define CONV_PSUM_PER_BEAT 2

// product stage then reduce stage then capture
`define CONV_COMPUTE_CYCLES 3

`endif

/* hw/conv_pkg.sv */
`default_nettype none
`include "conv_consts.svh"

package conv_pkg;

    // phase order of one job
    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,    // optional, skipped to reuse weights
        IFMAP_LOAD,
        IPSUM_LOAD,
        COMPUTE,
        OPSUM_OUT
    } conv_state_t;

    // job configuration, held stable for the whole job
    typedef struct packed {
        logic [3:0] row_en;     // active output channels 1 to 8
        logic [3:0] col_en;     // active input channels 1 to 8
    } conv_cfg_t;

    // strobe into a buffer or read index out of one
    typedef struct packed {
        logic                          en;
        logic [$clog2(`CONV_ROWS)-1:0] row;     // weight row only
        logic [2:0]                    beat;    // beat within the row or phase
    } beat_wr_t;

    // array control
    typedef struct packed {
        logic launch;           // load the product registers
        logic store;            // capture sums into opsum buffer
    } pe_ctrl_t;

    // row 0 sits in the low 16 bits
    typedef logic [`CONV_ROWS-1:0][`CONV_PSUM_W-1:0] psum_vec_t;

endpackage

`default_nettype wire

/* hw/conv_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module conv_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  conv_pkg::conv_cfg_t   cfg,
    input  logic                  valid_w,
    input  logic                  valid_if,
    input  logic                  valid_ip,
    input  logic                  ready_op,
    output logic                  ready_w,
    output logic                  ready_if,
    output logic                  ready_ip,
    output logic                  valid_op,
    output conv_pkg::beat_wr_t    weight_wr,
    output conv_pkg::beat_wr_t    ifmap_wr,
    output conv_pkg::beat_wr_t    ipsum_wr,
    output conv_pkg::beat_wr_t    opsum_rd,
    output conv_pkg::pe_ctrl_t    pe_ctrl,
    output conv_pkg::conv_state_t state
);

    conv_pkg::conv_state_t next_state;

    logic [2:0] beat_cnt;       // beat in phase or cycle in compute
    logic [2:0] row_cnt;        // weight row being filled
    logic [4:0] col_round;
    logic [4:0] row_round;
    logic [2:0] act_beats;      // ceil(col_en/4)
    logic [2:0] psum_beats;     // ceil(row_en/2)
    logic       xfer;           // some stream moves a beat this edge
    logic       last_act;
    logic       last_psum;
    logic       last_row;
    logic       phase_done;

    // ------------------------------------------------------------------
    // beat counts from the job config
    // ------------------------------------------------------------------
    assign col_round  = {1'b0, cfg.col_en} + 5'(`CONV_ACT_PER_BEAT - 1);
    assign row_round  = {1'b0, cfg.row_en} + 5'(`CONV_PSUM_PER_BEAT - 1);
    assign act_beats  = 3'(col_round / `CONV_ACT_PER_BEAT);
    assign psum_beats = 3'(row_round / `CONV_PSUM_PER_BEAT);

    assign last_act  = (beat_cnt == act_beats - 3'd1);
    assign last_psum = (beat_cnt == psum_beats - 3'd1);
    assign last_row  = ({1'b0, row_cnt} == cfg.row_en - 4'd1);

    assign xfer = (valid_w & ready_w) | (valid_if & ready_if) |
                  (valid_ip & ready_ip) | (valid_op & ready_op);

    // last edge of the current phase
    always_comb begin
        case (state)
            conv_pkg::WEIGHT_LOAD: phase_done = xfer & last_act & last_row;
            conv_pkg::IFMAP_LOAD:  phase_done = xfer & last_act;
            conv_pkg::IPSUM_LOAD:  phase_done = xfer & last_psum;
            conv_pkg::COMPUTE:     phase_done = (beat_cnt == 3'(`CONV_COMPUTE_CYCLES - 1));
            conv_pkg::OPSUM_OUT:   phase_done = xfer & last_psum;
            default:               phase_done = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // phase sequencing
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            conv_pkg::IDLE: begin
                if (valid_w)
                    next_state = conv_pkg::WEIGHT_LOAD;
                else if (valid_if)
                    next_state = conv_pkg::IFMAP_LOAD;  // keep stored weights
            end
            conv_pkg::WEIGHT_LOAD: if (phase_done) next_state = conv_pkg::IFMAP_LOAD;
            conv_pkg::IFMAP_LOAD:  if (phase_done) next_state = conv_pkg::IPSUM_LOAD;
            conv_pkg::IPSUM_LOAD:  if (phase_done) next_state = conv_pkg::COMPUTE;
            conv_pkg::COMPUTE:     if (phase_done) next_state = conv_pkg::OPSUM_OUT;
            conv_pkg::OPSUM_OUT:   if (phase_done) next_state = conv_pkg::IDLE;
            default:               next_state = conv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= conv_pkg::IDLE;
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else begin
            state <= next_state;
            if (phase_done) begin
                beat_cnt <= '0;
                row_cnt  <= '0;
            end else if (xfer || state == conv_pkg::COMPUTE) begin
                if (state == conv_pkg::WEIGHT_LOAD && last_act) begin
                    beat_cnt <= '0;                 // wrap to the next row
                    row_cnt  <= row_cnt + 3'd1;
                end else begin
                    beat_cnt <= beat_cnt + 3'd1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // handshake flags and strobes
    // ------------------------------------------------------------------
    assign ready_w  = (state == conv_pkg::WEIGHT_LOAD);
    assign ready_if = (state == conv_pkg::IFMAP_LOAD);
    assign ready_ip = (state == conv_pkg::IPSUM_LOAD);
    assign valid_op = (state == conv_pkg::OPSUM_OUT);

    assign weight_wr = '{en: valid_w & ready_w, row: row_cnt, beat: beat_cnt};
    assign ifmap_wr  = '{en: valid_if & ready_if, row: '0, beat: beat_cnt};
    assign ipsum_wr  = '{en: valid_ip & ready_ip, row: '0, beat: beat_cnt};
    assign opsum_rd  = '{en: valid_op & ready_op, row: '0, beat: beat_cnt};

    // launch on first compute cycle and store on the last
    assign pe_ctrl = '{
        launch: (state == conv_pkg::COMPUTE) && (beat_cnt == 3'd0),
        store:  (state == conv_pkg::COMPUTE) &&
                (beat_cnt == 3'(`CONV_COMPUTE_CYCLES - 1))
    };

    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ready_w, ready_if, ready_ip}));

    a_valid_op_state: assert property (@(posedge clk) disable iff (reset)
        valid_op |-> state == conv_pkg::OPSUM_OUT);

    // stalled output keeps its beat so data_out holds
    a_op_hold: assert property (@(posedge clk) disable iff (reset)
        valid_op && !ready_op |=> valid_op && $stable(opsum_rd.beat));

endmodule

`default_nettype wire

/* hw/weight_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module weight_buffer (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [`CONV_DATA_W-1:0]                     data_in,
    input  conv_pkg::beat_wr_t                          weight_wr,
    output logic [`CONV_ROWS*`CONV_COLS*`CONV_ACT_W-1:0] weights
);

    localparam int WORDS  = `CONV_COLS / `CONV_ACT_PER_BEAT;   // beats per row
    localparam int WORD_W = $clog2(WORDS);

    // row r word w holds channels 4w..4w+3, low byte first
    logic [`CONV_ROWS-1:0][WORDS-1:0][`CONV_DATA_W-1:0] weight_q;

    always_ff @(posedge clk) begin
        if (weight_wr.en)
            weight_q[weight_wr.row][weight_wr.beat[WORD_W-1:0]] <= data_in;
    end

    assign weights = weight_q;  // flat row major

    // controller must stay inside the array
    a_wr_range: assert property (@(posedge clk) disable iff (reset)
        weight_wr.en |-> (int'(weight_wr.row) < `CONV_ROWS) &&
                         (int'(weight_wr.beat) < WORDS));

endmodule

`default_nettype wire

/* hw/ifmap_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module ifmap_buffer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [`CONV_DATA_W-1:0]          data_in,
    input  conv_pkg::beat_wr_t               ifmap_wr,
    output logic [`CONV_COLS*`CONV_ACT_W-1:0] ifmap
);

    localparam int WORDS  = `CONV_COLS / `CONV_ACT_PER_BEAT;
    localparam int WORD_W = $clog2(WORDS);

    logic [WORDS-1:0][`CONV_DATA_W-1:0] ifmap_q;   // four activations per word

    always_ff @(posedge clk) begin
        if (reset)
            ifmap_q <= '0;
        else if (ifmap_wr.en)
            ifmap_q[ifmap_wr.beat[WORD_W-1:0]] <= data_in;
    end

    // channel c at bits c*8 up
    assign ifmap = ifmap_q;

endmodule

`default_nettype wire

/* hw/ipsum_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module ipsum_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CONV_DATA_W-1:0] data_in,
    input  conv_pkg::beat_wr_t      ipsum_wr,
    output conv_pkg::psum_vec_t     ipsum
);

    localparam int BEATS  = `CONV_ROWS / `CONV_PSUM_PER_BEAT;
    localparam int BEAT_W = $clog2(BEATS);

    // beat k carries row 2k low and row 2k+1 high
    logic [BEATS-1:0][`CONV_DATA_W-1:0] ipsum_q;

    always_ff @(posedge clk) begin
        if (reset)
            ipsum_q <= '0;
        else if (ipsum_wr.en)
            ipsum_q[ipsum_wr.beat[BEAT_W-1:0]] <= data_in;
    end

    assign ipsum = ipsum_q;     // same bit layout as psum_vec_t

endmodule

`default_nettype wire

/* hw/pe_array.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module pe_array (
    input  logic                                        clk,
    input  logic                                        reset,
    input  conv_pkg::conv_cfg_t                         cfg,
    input  conv_pkg::pe_ctrl_t                          pe_ctrl,
    input  logic [`CONV_ROWS*`CONV_COLS*`CONV_ACT_W-1:0] weights,
    input  logic [`CONV_COLS*`CONV_ACT_W-1:0]            ifmap,
    input  conv_pkg::psum_vec_t                         ipsum,
    output conv_pkg::psum_vec_t                         psum
);

    logic [`CONV_ROWS-1:0][`CONV_COLS-1:0][`CONV_PSUM_W-1:0] prod_q;
    logic                                                    prod_vld;  // stage 1 holds fresh data
    conv_pkg::psum_vec_t                                     row_sum;

    // 8x8 signed multiply, full product fits in 16 bits
    function automatic logic [`CONV_PSUM_W-1:0] smul(
        input logic [`CONV_ACT_W-1:0] a,
        input logic [`CONV_ACT_W-1:0] b
    );
        logic signed [`CONV_PSUM_W-1:0] a_ext;
        logic signed [`CONV_PSUM_W-1:0] b_ext;
        a_ext = {{(`CONV_PSUM_W-`CONV_ACT_W){a[`CONV_ACT_W-1]}}, a};
        b_ext = {{(`CONV_PSUM_W-`CONV_ACT_W){b[`CONV_ACT_W-1]}}, b};
        return a_ext * b_ext;
    endfunction

    // ------------------------------------------------------------------
    // stage 1 products with channel mask
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pe_ctrl.launch) begin
            for (int r = 0; r < `CONV_ROWS; r++) begin
                for (int c = 0; c < `CONV_COLS; c++) begin
                    if (c < int'(cfg.col_en))
                        prod_q[r][c] <= smul(weights[(r*`CONV_COLS+c)*`CONV_ACT_W +: `CONV_ACT_W],
                                             ifmap[c*`CONV_ACT_W +: `CONV_ACT_W]);
                    else
                        prod_q[r][c] <= '0;     // inactive channel
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            prod_vld <= 1'b0;
        else
            prod_vld <= pe_ctrl.launch;
    end

    // ------------------------------------------------------------------
    // stage 2 row reduce plus ipsum
    // ------------------------------------------------------------------
    always_comb begin
        for (int r = 0; r < `CONV_ROWS; r++) begin
            row_sum[r] = ipsum[r];
            for (int c = 0; c < `CONV_COLS; c++)
                row_sum[r] = row_sum[r] + prod_q[r][c];    // wraps at 16 bits
        end
    end

    always_ff @(posedge clk) begin
        if (prod_vld)
            psum <= row_sum;
    end

endmodule

`default_nettype wire

/* hw/opsum_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module opsum_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  conv_pkg::pe_ctrl_t      pe_ctrl,
    input  conv_pkg::psum_vec_t     psum,
    input  conv_pkg::beat_wr_t      opsum_rd,
    input  conv_pkg::conv_state_t   state,
    output logic [`CONV_DATA_W-1:0] data_out
);

    localparam int BEATS  = `CONV_ROWS / `CONV_PSUM_PER_BEAT;
    localparam int BEAT_W = $clog2(BEATS);

    // two sums per word, even row in the low half
    logic [BEATS-1:0][`CONV_DATA_W-1:0] opsum_q;

    always_ff @(posedge clk) begin
        if (pe_ctrl.store)
            opsum_q <= psum;    // last compute cycle
    end

    // addressed beat goes straight out, zero outside the output phase
    assign data_out = (state == conv_pkg::OPSUM_OUT) ?
                      opsum_q[opsum_rd.beat[BEAT_W-1:0]] : '0;

    a_rd_range: assert property (@(posedge clk) disable iff (reset)
        state == conv_pkg::OPSUM_OUT |-> int'(opsum_rd.beat) < BEATS);

endmodule

`default_nettype wire

/* hw/conv_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module conv_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CONV_DATA_W-1:0] data_in,     // from glb
    output logic [`CONV_DATA_W-1:0] data_out,    // to glb
    input  conv_pkg::conv_cfg_t     cfg,
    input  logic                    valid_w,
    input  logic                    valid_if,
    input  logic                    valid_ip,
    input  logic                    ready_op,
    output logic                    ready_w,
    output logic                    ready_if,
    output logic                    ready_ip,
    output logic                    valid_op
);

    // control out of the FSM
    conv_pkg::beat_wr_t    weight_wr;
    conv_pkg::beat_wr_t    ifmap_wr;
    conv_pkg::beat_wr_t    ipsum_wr;
    conv_pkg::beat_wr_t    opsum_rd;
    conv_pkg::pe_ctrl_t    pe_ctrl;
    conv_pkg::conv_state_t state;

    // datapath between buffers and array
    logic [`CONV_ROWS*`CONV_COLS*`CONV_ACT_W-1:0] weights;
    logic [`CONV_COLS*`CONV_ACT_W-1:0]            ifmap;
    conv_pkg::psum_vec_t                          ipsum;
    conv_pkg::psum_vec_t                          psum;

    conv_ctrl conv_ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .valid_w   (valid_w),
        .valid_if  (valid_if),
        .valid_ip  (valid_ip),
        .ready_op  (ready_op),
        .ready_w   (ready_w),
        .ready_if  (ready_if),
        .ready_ip  (ready_ip),
        .valid_op  (valid_op),
        .weight_wr (weight_wr),
        .ifmap_wr  (ifmap_wr),
        .ipsum_wr  (ipsum_wr),
        .opsum_rd  (opsum_rd),
        .pe_ctrl   (pe_ctrl),
        .state     (state)
    );

    weight_buffer weight_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .data_in   (data_in),
        .weight_wr (weight_wr),
        .weights   (weights)
    );

    ifmap_buffer ifmap_buffer_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .ifmap_wr (ifmap_wr),
        .ifmap    (ifmap)
    );

    ipsum_buffer ipsum_buffer_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .ipsum_wr (ipsum_wr),
        .ipsum    (ipsum)
    );

    pe_array pe_array_inst (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .pe_ctrl (pe_ctrl),
        .weights (weights),
        .ifmap   (ifmap),
        .ipsum   (ipsum),
        .psum    (psum)
    );

    opsum_buffer opsum_buffer_inst (
        .clk      (clk),
        .reset    (reset),
        .pe_ctrl  (pe_ctrl),
        .psum     (psum),
        .opsum_rd (opsum_rd),
        .state    (state),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter real period_ns = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;     // first rising edge at half a period

    always #(period_ns / 2.0) clk = ~clk;

endmodule

`default_nettype wire

/* tb/tb_conv_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_consts.svh"

module tb_conv_unit;

    localparam int job_count   = 40;
    localparam int cycle_limit = job_count * 80 + 20;  // 80 cycles per job plus reset
    localparam int kind_w      = 0;                    // stream selectors
    localparam int kind_if     = 1;
    localparam int kind_ip     = 2;

    logic                    clk;
    logic                    reset;
    logic [`CONV_DATA_W-1:0] data_in;
    logic [`CONV_DATA_W-1:0] data_out;
    conv_pkg::conv_cfg_t     cfg;
    logic                    valid_w;
    logic                    valid_if;
    logic                    valid_ip;
    logic                    ready_op;
    logic                    ready_w;
    logic                    ready_if;
    logic                    ready_ip;
    logic                    valid_op;

    int errors    = 0;
    int cycle_cnt = 0;
    int jobs_done = 0;

    // reference model state
    logic [`CONV_ACT_W-1:0]  w_model  [`CONV_ROWS][`CONV_COLS];
    logic [`CONV_ACT_W-1:0]  x_model  [`CONV_COLS];
    logic [`CONV_PSUM_W-1:0] ip_model [`CONV_ROWS];
    logic [`CONV_DATA_W-1:0] exp_q[$];     // expected opsum beats
    logic [`CONV_DATA_W-1:0] mask_q[$];    // odd row_en leaves a dead high half

    tb_clk_gen #(.period_ns(4.0)) tb_clk_gen_inst (.clk(clk));

    conv_unit conv_unit_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .data_out (data_out),
        .cfg      (cfg),
        .valid_w  (valid_w),
        .valid_if (valid_if),
        .valid_ip (valid_ip),
        .ready_op (ready_op),
        .ready_w  (ready_w),
        .ready_if (ready_if),
        .ready_ip (ready_ip),
        .valid_op (valid_op)
    );

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input logic [`CONV_DATA_W-1:0] expected,
                              input logic [`CONV_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected 0x%08h got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_state_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // stream drivers, all called right after a falling edge
    // ------------------------------------------------------------------
    task automatic drive_quiet();
        valid_w  = 1'b0;
        valid_if = 1'b0;
        valid_ip = 1'b0;
        data_in  = $urandom;    // junk on an idle bus
    endtask

    task automatic drive_valid(input int kind, input logic [`CONV_DATA_W-1:0] word);
        valid_w  = (kind == kind_w);
        valid_if = (kind == kind_if);
        valid_ip = (kind == kind_ip);
        data_in  = word;
    endtask

    function automatic logic ready_for(input int kind);
        case (kind)
            kind_w:  return ready_w;
            kind_if: return ready_if;
            default: return ready_ip;
        endcase
    endfunction

    // gaps only before valid rises, never once it is up
    task automatic send_beats(input int kind, input logic [`CONV_DATA_W-1:0] beats[$]);
        int gap;
        foreach (beats[i]) begin
            gap = ($urandom % 4 == 0) ? 1 + $urandom % 2 : 0;
            repeat (gap) begin
                @(negedge clk);
                drive_quiet();
            end
            @(negedge clk);
            drive_valid(kind, beats[i]);
            while (!ready_for(kind))
                @(negedge clk);     // beat moves on the next rising edge
        end
    endtask

    task automatic receive_opsum();
        int                      got;
        logic                    stalled;
        logic [`CONV_DATA_W-1:0] held;
        got     = 0;
        stalled = 1'b0;
        held    = '0;
        while (got < exp_q.size()) begin
            @(negedge clk);
            drive_quiet();
            if (stalled)
                check_word("data_out held while stalled", held, data_out);
            ready_op = ($urandom % 3) != 0;
            if (valid_op && ready_op) begin
                check_word("data_out", exp_q[got] & mask_q[got], data_out & mask_q[got]);
                got++;
                stalled = 1'b0;
            end else if (valid_op) begin
                stalled = 1'b1;     // back-pressure this cycle
                held    = data_out;
            end else begin
                stalled = 1'b0;
            end
        end
        @(negedge clk);
        ready_op = 1'b0;
        check_state_flag("valid_op after last beat", 1'b0, valid_op);    // beat count exact
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    task automatic build_expected(input int psum_beats);
        logic [`CONV_PSUM_W-1:0] acc [`CONV_ROWS];
        int                      prod;
        exp_q.delete();
        mask_q.delete();
        for (int r = 0; r < `CONV_ROWS; r++) begin
            acc[r] = ip_model[r];
            for (int c = 0; c < int'(cfg.col_en); c++) begin
                prod  = int'($signed(w_model[r][c])) * int'($signed(x_model[c]));
                acc[r] = acc[r] + prod[15:0];   // 16 bit wrap
            end
        end
        for (int k = 0; k < psum_beats; k++) begin
            exp_q.push_back({acc[2*k+1], acc[2*k]});
            mask_q.push_back((2 * k + 1 < int'(cfg.row_en)) ? 32'hffff_ffff : 32'h0000_ffff);
        end
    endtask

    // one job, optionally with fresh weights and config
    task automatic run_job(input logic new_w, input logic full_cfg);
        logic [`CONV_DATA_W-1:0] beats[$];
        logic [`CONV_DATA_W-1:0] word;
        int                      act_beats;
        int                      psum_beats;
        if (new_w) begin
            if (full_cfg) begin
                cfg = '{row_en: 4'd8, col_en: 4'd8};
            end else begin
                cfg.row_en = 4'(1 + $urandom % 8);
                cfg.col_en = 4'(1 + $urandom % 8);
            end
            for (int r = 0; r < `CONV_ROWS; r++)
                for (int c = 0; c < `CONV_COLS; c++)
                    w_model[r][c] = 8'($urandom);
        end
        act_beats  = (int'(cfg.col_en) + 3) / 4;
        psum_beats = (int'(cfg.row_en) + 1) / 2;
        for (int c = 0; c < `CONV_COLS; c++)
            x_model[c] = 8'($urandom);      // bytes past col_en are junk
        for (int r = 0; r < `CONV_ROWS; r++)
            ip_model[r] = 16'($urandom);

        if (new_w) begin
            beats.delete();
            for (int r = 0; r < int'(cfg.row_en); r++) begin
                for (int b = 0; b < act_beats; b++) begin
                    for (int k = 0; k < 4; k++)
                        word[k*8 +: 8] = w_model[r][4*b+k];
                    beats.push_back(word);
                end
            end
            send_beats(kind_w, beats);
        end

        beats.delete();
        for (int b = 0; b < act_beats; b++) begin
            for (int k = 0; k < 4; k++)
                word[k*8 +: 8] = x_model[4*b+k];
            beats.push_back(word);
        end
        send_beats(kind_if, beats);

        beats.delete();
        for (int k = 0; k < psum_beats; k++)
            beats.push_back({ip_model[2*k+1], ip_model[2*k]});
        send_beats(kind_ip, beats);

        build_expected(psum_beats);
        receive_opsum();
        jobs_done++;
    endtask

    // ------------------------------------------------------------------
    // monitors and main sequence
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset && !valid_op)
            check_word("data_out outside OPSUM_OUT", '0, data_out);
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run hung after %0d cycles, %0d jobs done, %0d errors",
                     cycle_cnt, jobs_done, errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h5a42));
        reset    = 1'b1;
        data_in  = '0;
        cfg      = '{row_en: 4'd8, col_en: 4'd8};
        valid_w  = 1'b0;
        valid_if = 1'b0;
        valid_ip = 1'b0;
        ready_op = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);     // quiet state after reset
        check_state_flag("ready_w after reset", 1'b0, ready_w);
        check_state_flag("ready_if after reset", 1'b0, ready_if);
        check_state_flag("ready_ip after reset", 1'b0, ready_ip);
        check_state_flag("valid_op after reset", 1'b0, valid_op);
        check_word("data_out after reset", '0, data_out);

        run_job(1'b1, 1'b1);    // full array, new weights
        run_job(1'b0, 1'b0);    // weight reuse
        for (int j = 2; j < job_count; j++)
            run_job(($urandom % 3) != 0, 1'b0);

        $display("Jobs run: %0d, errors: %0d", jobs_done, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/conv_pkg.sv
hw/conv_ctrl.sv
hw/weight_buffer.sv
hw/ifmap_buffer.sv
hw/ipsum_buffer.sv
hw/pe_array.sv
hw/opsum_buffer.sv
hw/conv_unit.sv
tb/tb_clk_gen.sv
tb/tb_conv_unit.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_conv_unit || exit 1
out=$(./obj_dir/Vtb_conv_unit)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && echo "run passed" || { echo "run failed"; exit 1; }
